// File: rtl/riscv_isa_pkg.sv
// isa types: data word, register index, opcode, funct, alu and forwarding enums, instr fields
package riscv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // funct3 of the register and immediate alu ops
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // r-type layout, all formats keep opcode, rd, funct3 and rs1 here
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_fields_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: rtl/pipe_pkg.sv
// pipeline types: control bundle, stage registers and data-memory request
package pipe_pkg;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   branch;
        logic                   branch_ne;
        logic                   jump;
        logic                   alu_src;
        riscv_isa_pkg::alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        riscv_isa_pkg::word_t pc;
        riscv_isa_pkg::word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        riscv_isa_pkg::word_t    pc;
        riscv_isa_pkg::word_t    rs1_data;
        riscv_isa_pkg::word_t    rs2_data;
        riscv_isa_pkg::word_t    imm;
        riscv_isa_pkg::reg_idx_t rs1;
        riscv_isa_pkg::reg_idx_t rs2;
        riscv_isa_pkg::reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        logic                    reg_write;
        logic                    mem_read;
        logic                    mem_write;
        logic                    jump;
        riscv_isa_pkg::word_t    alu_result;
        riscv_isa_pkg::word_t    store_data;
        riscv_isa_pkg::word_t    link;
        riscv_isa_pkg::reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic                    reg_write;
        logic                    mem_read;
        logic                    jump;
        riscv_isa_pkg::word_t    alu_result;
        riscv_isa_pkg::word_t    load_data;
        riscv_isa_pkg::word_t    link;
        riscv_isa_pkg::reg_idx_t rd;
    } mem_wb_t;

    // word-addressed single-cycle request
    typedef struct packed {
        logic                 read;
        logic                 write;
        logic [29:0]          addr;
        riscv_isa_pkg::word_t wdata;
    } dmem_req_t;

endpackage

// File: rtl/fetch_stage.sv
// fetch stage: pc register, next-pc select and IF/ID register
module fetch_stage #(
    parameter riscv_isa_pkg::word_t RESET_PC = 32'h0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 redirect,
    input  riscv_isa_pkg::word_t redirect_pc,
    output riscv_isa_pkg::word_t imem_addr,
    input  riscv_isa_pkg::word_t imem_rdata,
    output pipe_pkg::if_id_t     if_id
);

    riscv_isa_pkg::word_t pc;
    riscv_isa_pkg::word_t pc_next;

    assign imem_addr = pc;

    // redirect wins, it never coincides with a load-use stall
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // IF/ID, squashed to a nop when EX redirects
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id <= '{pc: RESET_PC, instr: riscv_isa_pkg::NOP_INSTR};
        end else if (redirect) begin
            if_id <= '{pc: pc, instr: riscv_isa_pkg::NOP_INSTR};
        end else if (!stall) begin
            if_id <= '{pc: pc, instr: imem_rdata};
        end
    end

endmodule

// File: rtl/decode_stage.sv
// decode stage: control decode, immediate generation and ID/EX register
module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    flush,
    input  pipe_pkg::if_id_t        if_id,
    output riscv_isa_pkg::reg_idx_t rs1_idx,
    output riscv_isa_pkg::reg_idx_t rs2_idx,
    input  riscv_isa_pkg::word_t    rs1_data,
    input  riscv_isa_pkg::word_t    rs2_data,
    output pipe_pkg::id_ex_t        id_ex
);

    riscv_isa_pkg::word_t          ins;
    riscv_isa_pkg::instr_fields_t  fields;
    riscv_isa_pkg::opcode_e        opcode;
    riscv_isa_pkg::funct3_e        funct3;
    riscv_isa_pkg::word_t          imm;
    pipe_pkg::ctrl_t               ctrl;
    pipe_pkg::id_ex_t              id_ex_d;

    function automatic riscv_isa_pkg::alu_op_e alu_decode(
        input riscv_isa_pkg::funct3_e f3,
        input logic                   sub
    );
        case (f3)
            riscv_isa_pkg::F3_ADD: alu_decode = sub ? riscv_isa_pkg::ALU_SUB
                                                    : riscv_isa_pkg::ALU_ADD;
            riscv_isa_pkg::F3_SLT: alu_decode = riscv_isa_pkg::ALU_SLT;
            riscv_isa_pkg::F3_XOR: alu_decode = riscv_isa_pkg::ALU_XOR;
            riscv_isa_pkg::F3_OR:  alu_decode = riscv_isa_pkg::ALU_OR;
            riscv_isa_pkg::F3_AND: alu_decode = riscv_isa_pkg::ALU_AND;
            default:               alu_decode = riscv_isa_pkg::ALU_ADD;
        endcase
    endfunction

    assign ins     = if_id.instr;
    assign fields  = ins;
    assign opcode  = riscv_isa_pkg::opcode_e'(fields.opcode);
    assign funct3  = riscv_isa_pkg::funct3_e'(fields.funct3);
    assign rs1_idx = fields.rs1;
    assign rs2_idx = fields.rs2;

    // ----------------------------------------------------------------------
    // control decode
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = riscv_isa_pkg::ALU_ADD;
        case (opcode)
            riscv_isa_pkg::OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, fields.funct7 == riscv_isa_pkg::F7_SUB);
            end
            riscv_isa_pkg::OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, 1'b0);
            end
            riscv_isa_pkg::LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            riscv_isa_pkg::STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            riscv_isa_pkg::BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = fields.funct3[0];
            end
            riscv_isa_pkg::JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
            end
            default: ;
        endcase
    end

    // immediates, I format unless the opcode says otherwise
    always_comb begin
        case (opcode)
            riscv_isa_pkg::STORE:  imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            riscv_isa_pkg::BRANCH: imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                          ins[11:8], 1'b0};
            riscv_isa_pkg::JAL:    imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                          ins[30:21], 1'b0};
            default:               imm = {{20{ins[31]}}, ins[31:20]};
        endcase
    end

    // ----------------------------------------------------------------------
    // ID/EX register, stall or flush leaves a bubble
    always_comb begin
        id_ex_d.ctrl     = (stall || flush) ? '0 : ctrl;
        id_ex_d.pc       = if_id.pc;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm;
        id_ex_d.rs1      = fields.rs1;
        id_ex_d.rs2      = fields.rs2;
        id_ex_d.rd       = fields.rd;
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_d;
        if (!rst_n) begin
            id_ex.ctrl <= '0;
        end
    end

endmodule

// File: rtl/reg_file.sv
// register file: 31 writable registers, x0 reads zero, write-first bypass
module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  riscv_isa_pkg::reg_idx_t rs1_idx,
    input  riscv_isa_pkg::reg_idx_t rs2_idx,
    output riscv_isa_pkg::word_t    rs1_data,
    output riscv_isa_pkg::word_t    rs2_data,
    input  logic                    wb_en,
    input  riscv_isa_pkg::reg_idx_t wb_rd,
    input  riscv_isa_pkg::word_t    wb_data
);

    riscv_isa_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst_n && wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-cycle write shows up on the read ports
    assign rs1_data = (rs1_idx == '0) ? '0 :
                      (wb_en && wb_rd == rs1_idx) ? wb_data : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 :
                      (wb_en && wb_rd == rs2_idx) ? wb_data : regs[rs2_idx];

endmodule

// File: rtl/hazard_unit.sv
// hazard unit: EX operand forwarding select and load-use stall
module hazard_unit (
    input  pipe_pkg::id_ex_t         id_ex,
    input  pipe_pkg::ex_mem_t        ex_mem,
    input  pipe_pkg::mem_wb_t        mem_wb,
    input  riscv_isa_pkg::reg_idx_t  rs1_idx,
    input  riscv_isa_pkg::reg_idx_t  rs2_idx,
    output riscv_isa_pkg::fwd_sel_e  fwd_a,
    output riscv_isa_pkg::fwd_sel_e  fwd_b,
    output logic                     stall
);

    // nearest producer first
    function automatic riscv_isa_pkg::fwd_sel_e pick_src(
        input riscv_isa_pkg::reg_idx_t src,
        input pipe_pkg::ex_mem_t       mem,
        input pipe_pkg::mem_wb_t       wb
    );
        if (mem.reg_write && mem.rd != '0 && mem.rd == src) begin
            pick_src = riscv_isa_pkg::FWD_MEM;
        end else if (wb.reg_write && wb.rd != '0 && wb.rd == src) begin
            pick_src = riscv_isa_pkg::FWD_WB;
        end else begin
            pick_src = riscv_isa_pkg::FWD_NONE;
        end
    endfunction

    assign fwd_a = pick_src(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = pick_src(id_ex.rs2, ex_mem, mem_wb);

    // load in EX feeding the instruction in ID
    assign stall = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                   (id_ex.rd == rs1_idx || id_ex.rd == rs2_idx);

endmodule

// File: rtl/execute_stage.sv
// execute stage: forwarding muxes, alu, branch resolve, EX/MEM register, dmem request
module execute_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pipe_pkg::id_ex_t        id_ex,
    input  riscv_isa_pkg::fwd_sel_e fwd_a,
    input  riscv_isa_pkg::fwd_sel_e fwd_b,
    input  riscv_isa_pkg::word_t    wb_data,
    output logic                    redirect,
    output riscv_isa_pkg::word_t    redirect_pc,
    output pipe_pkg::ex_mem_t       ex_mem,
    output pipe_pkg::dmem_req_t     dmem_req
);

    riscv_isa_pkg::word_t mem_fwd;
    riscv_isa_pkg::word_t op_a;
    riscv_isa_pkg::word_t rs2_val;
    riscv_isa_pkg::word_t op_b;
    riscv_isa_pkg::word_t alu_result;
    logic                 taken;
    pipe_pkg::ex_mem_t    ex_mem_d;

    function automatic riscv_isa_pkg::word_t fwd_mux(
        input riscv_isa_pkg::fwd_sel_e sel,
        input riscv_isa_pkg::word_t    reg_val,
        input riscv_isa_pkg::word_t    mem_val,
        input riscv_isa_pkg::word_t    wb_val
    );
        case (sel)
            riscv_isa_pkg::FWD_MEM: fwd_mux = mem_val;
            riscv_isa_pkg::FWD_WB:  fwd_mux = wb_val;
            default:                fwd_mux = reg_val;
        endcase
    endfunction

    // a jal in MEM forwards its link value
    assign mem_fwd = ex_mem.jump ? ex_mem.link : ex_mem.alu_result;
    assign op_a    = fwd_mux(fwd_a, id_ex.rs1_data, mem_fwd, wb_data);
    assign rs2_val = fwd_mux(fwd_b, id_ex.rs2_data, mem_fwd, wb_data);
    assign op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            riscv_isa_pkg::ALU_SUB: alu_result = op_a - op_b;
            riscv_isa_pkg::ALU_AND: alu_result = op_a & op_b;
            riscv_isa_pkg::ALU_OR:  alu_result = op_a | op_b;
            riscv_isa_pkg::ALU_XOR: alu_result = op_a ^ op_b;
            riscv_isa_pkg::ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            default:                alu_result = op_a + op_b;
        endcase
    end

    // ----------------------------------------------------------------------
    // branch and jal resolve here
    assign taken       = id_ex.ctrl.branch && ((op_a == rs2_val) != id_ex.ctrl.branch_ne);
    assign redirect    = taken || id_ex.ctrl.jump;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_comb begin
        ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_d.jump       = id_ex.ctrl.jump;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = rs2_val;
        ex_mem_d.link       = id_ex.pc + 32'd4;
        ex_mem_d.rd         = id_ex.rd;
    end

    always_ff @(posedge clk) begin
        ex_mem <= ex_mem_d;
        if (!rst_n) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.jump      <= 1'b0;
        end
    end

    assign dmem_req = '{read:  ex_mem.mem_read,
                        write: ex_mem.mem_write,
                        addr:  ex_mem.alu_result[31:2],
                        wdata: ex_mem.store_data};

endmodule

// File: rtl/writeback_stage.sv
// writeback stage: MEM/WB register and result select
module writeback_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pipe_pkg::ex_mem_t       ex_mem,
    input  riscv_isa_pkg::word_t    dmem_rdata,
    output pipe_pkg::mem_wb_t       mem_wb,
    output logic                    wb_en,
    output riscv_isa_pkg::reg_idx_t wb_rd,
    output riscv_isa_pkg::word_t    wb_data
);

    // load data is captured as it returns
    always_ff @(posedge clk) begin
        mem_wb <= '{reg_write:  ex_mem.reg_write,
                    mem_read:   ex_mem.mem_read,
                    jump:       ex_mem.jump,
                    alu_result: ex_mem.alu_result,
                    load_data:  dmem_rdata,
                    link:       ex_mem.link,
                    rd:         ex_mem.rd};
        if (!rst_n) begin
            mem_wb.reg_write <= 1'b0;
            mem_wb.mem_read  <= 1'b0;
            mem_wb.jump      <= 1'b0;
        end
    end

    assign wb_en   = mem_wb.reg_write;
    assign wb_rd   = mem_wb.rd;
    assign wb_data = mem_wb.jump     ? mem_wb.link :
                     mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// File: rtl/riscv_core.sv
// core top: five-stage pipeline wiring
module riscv_core #(
    parameter riscv_isa_pkg::word_t RESET_PC = 32'h0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output riscv_isa_pkg::word_t imem_addr,
    input  riscv_isa_pkg::word_t imem_rdata,
    output pipe_pkg::dmem_req_t  dmem_req,
    input  riscv_isa_pkg::word_t dmem_rdata
);

    pipe_pkg::if_id_t        if_id;
    pipe_pkg::id_ex_t        id_ex;
    pipe_pkg::ex_mem_t       ex_mem;
    pipe_pkg::mem_wb_t       mem_wb;
    riscv_isa_pkg::reg_idx_t rs1_idx;
    riscv_isa_pkg::reg_idx_t rs2_idx;
    riscv_isa_pkg::word_t    rs1_data;
    riscv_isa_pkg::word_t    rs2_data;
    riscv_isa_pkg::fwd_sel_e fwd_a;
    riscv_isa_pkg::fwd_sel_e fwd_b;
    logic                    stall;
    logic                    redirect;
    riscv_isa_pkg::word_t    redirect_pc;
    logic                    wb_en;
    riscv_isa_pkg::reg_idx_t wb_rd;
    riscv_isa_pkg::word_t    wb_data;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_inst (
        .clk(clk), .rst_n(rst_n), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .if_id(if_id)
    );

    decode_stage decode_stage_inst (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(redirect), .if_id(if_id),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .id_ex(id_ex)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst_n(rst_n), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    hazard_unit hazard_unit_inst (
        .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb), .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx), .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
    );

    execute_stage execute_stage_inst (
        .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .wb_data(wb_data), .redirect(redirect), .redirect_pc(redirect_pc),
        .ex_mem(ex_mem), .dmem_req(dmem_req)
    );

    writeback_stage writeback_stage_inst (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .dmem_rdata(dmem_rdata),
        .mem_wb(mem_wb), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

// File: dv/riscv_core_assert.sv
// concurrent checks on the data-memory strobes, bound into the core top
module riscv_core_assert (
    input logic                clk,
    input logic                rst_n,
    input pipe_pkg::dmem_req_t dmem_req
);
    timeunit 1ns;
    timeprecision 1ps;

    one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_req.read && dmem_req.write))
        else $error("read and write strobes high together");

    // sync reset clears the strobes one edge later
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> !(dmem_req.read || dmem_req.write))
        else $error("strobe fired while in reset");

    single_write: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.write |=> !(dmem_req.write && $stable(dmem_req.addr)))
        else $error("write strobe held for two cycles");

    single_read: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.read |=> !(dmem_req.read && $stable(dmem_req.addr)))
        else $error("read strobe held for two cycles");

endmodule

bind riscv_core riscv_core_assert riscv_core_assert_inst (
    .clk(clk), .rst_n(rst_n), .dmem_req(dmem_req)
);

// File: dv/riscv_core_tb.sv
// clock, reset, memory models, program builder, directed tests and compare tasks
module riscv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam riscv_isa_pkg::word_t RESET_PC = 32'h0;
    localparam int STORE_TIMEOUT = 100;

    logic                 clk = 1'b0;
    logic                 rst_n = 1'b0;
    riscv_isa_pkg::word_t imem_addr;
    riscv_isa_pkg::word_t imem_rdata;
    pipe_pkg::dmem_req_t  dmem_req;
    riscv_isa_pkg::word_t dmem_rdata;

    riscv_isa_pkg::word_t imem [0:63];
    riscv_isa_pkg::word_t dmem [0:255];
    pipe_pkg::dmem_req_t  expected [$];
    int                   prog_len;
    integer               seed;

    riscv_core #(.RESET_PC(RESET_PC)) riscv_core_inst (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata)
    );

    always #20 clk = ~clk;

    // single-cycle memories with same-cycle read data
    assign imem_rdata = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_req.addr[7:0]];

    always @(posedge clk) begin
        if (dmem_req.write) begin
            dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
        end
    end

    // ----------------------------------------------------------------------
    // instruction encodings
    function automatic riscv_isa_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
        input riscv_isa_pkg::reg_idx_t rd, input riscv_isa_pkg::reg_idx_t rs1,
        input riscv_isa_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, riscv_isa_pkg::OP};
    endfunction

    function automatic riscv_isa_pkg::word_t i_type(input riscv_isa_pkg::opcode_e op,
        input logic [2:0] f3, input riscv_isa_pkg::reg_idx_t rd,
        input riscv_isa_pkg::reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // sw rs2, imm(x0)
    function automatic riscv_isa_pkg::word_t s_type(input riscv_isa_pkg::reg_idx_t rs2,
        input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], riscv_isa_pkg::STORE};
    endfunction

    function automatic riscv_isa_pkg::word_t b_type(input logic [2:0] f3,
        input riscv_isa_pkg::reg_idx_t rs1, input riscv_isa_pkg::reg_idx_t rs2,
        input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], riscv_isa_pkg::BRANCH};
    endfunction

    function automatic riscv_isa_pkg::word_t j_type(input riscv_isa_pkg::reg_idx_t rd,
        input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, riscv_isa_pkg::JAL};
    endfunction

    function automatic riscv_isa_pkg::word_t fill_word(input int idx);
        return {8'hd0, ~idx[7:0], 8'h5a, idx[7:0]};
    endfunction

    function automatic riscv_isa_pkg::word_t sign_extend(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // ----------------------------------------------------------------------
    // program builder and run control
    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_store(input pipe_pkg::dmem_req_t got, input pipe_pkg::dmem_req_t exp);
        if (got.addr !== exp.addr || got.wdata !== exp.wdata) begin
            $display("Error at %0t: store to word %h data %h, expected word %h data %h",
                     $time, got.addr, got.wdata, exp.addr, exp.wdata);
            stop_with_failure();
        end
    endtask

    task automatic check_addr(input riscv_isa_pkg::word_t got, input riscv_isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: fetch address %h, expected %h", $time, got, exp);
            stop_with_failure();
        end
    endtask

    // reset is held while the program is written
    task automatic start_program();
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = riscv_isa_pkg::NOP_INSTR;
        end
        prog_len = 0;
        expected.delete();
    endtask

    task automatic emit(input riscv_isa_pkg::word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic set_reg(input riscv_isa_pkg::reg_idx_t rd, input logic [11:0] imm);
        emit(i_type(riscv_isa_pkg::OP_IMM, 3'b000, rd, 5'd0, imm));
    endtask

    task automatic store_and_expect(input riscv_isa_pkg::reg_idx_t rs2, input logic [11:0] off,
                                    input riscv_isa_pkg::word_t data);
        pipe_pkg::dmem_req_t req;
        req.read  = 1'b0;
        req.write = 1'b1;
        req.addr  = {20'd0, off[11:2]};
        req.wdata = data;
        emit(s_type(rs2, off));
        expected.push_back(req);
    endtask

    task automatic wait_store(input bit reads_ok, output pipe_pkg::dmem_req_t got);
        int cycles;
        bit found;
        cycles = 0;
        found  = 1'b0;
        got    = '0;
        while (!found && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (dmem_req.read && !reads_ok) begin
                $display("load strobe at %0t in a program without loads", $time);
                stop_with_failure();
            end else if (dmem_req.write) begin
                found = 1'b1;
                got   = dmem_req;
            end
        end
        if (!found) begin
            $display("no store seen within %0d cycles", STORE_TIMEOUT);
            stop_with_failure();
        end
    endtask

    // appends a jal-to-self spin and releases reset
    task automatic run_program(input bit reads_ok);
        pipe_pkg::dmem_req_t got;
        pipe_pkg::dmem_req_t exp;
        emit(j_type(5'd0, 21'd0));
        repeat (3) @(posedge clk);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_addr(imem_addr, RESET_PC);
        while (expected.size() > 0) begin
            exp = expected.pop_front();
            wait_store(reads_ok, got);
            check_store(got, exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    task automatic test_reset_state();
        start_program();
        set_reg(5'd1, 12'h2a5);
        store_and_expect(5'd1, 12'h100, 32'h0000_02a5);
        run_program(1'b0);
    endtask

    task automatic test_alu_ops();
        riscv_isa_pkg::word_t r;
        logic [11:0]          a_imm;
        logic [11:0]          b_imm;
        riscv_isa_pkg::word_t a;
        riscv_isa_pkg::word_t b;
        r     = $random(seed);
        a_imm = r[11:0];
        r     = $random(seed);
        b_imm = r[11:0];
        a     = sign_extend(a_imm);
        b     = sign_extend(b_imm);
        start_program();
        set_reg(5'd1, a_imm);
        set_reg(5'd2, b_imm);
        emit(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        store_and_expect(5'd3, 12'h100, a + b);
        emit(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
        store_and_expect(5'd4, 12'h104, a - b);
        emit(r_type(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        store_and_expect(5'd5, 12'h108, a & b);
        emit(r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
        store_and_expect(5'd6, 12'h10c, a | b);
        emit(r_type(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
        store_and_expect(5'd7, 12'h110, a ^ b);
        emit(r_type(7'h00, 3'b010, 5'd8, 5'd1, 5'd2));
        store_and_expect(5'd8, 12'h114, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        emit(r_type(7'h00, 3'b010, 5'd9, 5'd2, 5'd1));
        store_and_expect(5'd9, 12'h118, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        // -1 < 1 only when compared signed
        set_reg(5'd10, 12'hfff);
        set_reg(5'd11, 12'h001);
        emit(r_type(7'h00, 3'b010, 5'd12, 5'd10, 5'd11));
        store_and_expect(5'd12, 12'h11c, 32'd1);
        run_program(1'b0);
    endtask

    task automatic test_forwarding();
        riscv_isa_pkg::word_t r;
        logic [11:0]          a_imm;
        logic [11:0]          b_imm;
        riscv_isa_pkg::word_t x2;
        riscv_isa_pkg::word_t x3;
        riscv_isa_pkg::word_t x4;
        r     = $random(seed);
        a_imm = r[11:0];
        r     = $random(seed);
        b_imm = r[11:0];
        x2    = sign_extend(a_imm) + sign_extend(b_imm);
        x3    = x2 + sign_extend(a_imm);
        x4    = x3 + x3;
        start_program();
        set_reg(5'd1, a_imm);
        emit(i_type(riscv_isa_pkg::OP_IMM, 3'b000, 5'd2, 5'd1, b_imm));
        emit(r_type(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
        emit(r_type(7'h00, 3'b000, 5'd4, 5'd3, 5'd3));
        emit(r_type(7'h20, 3'b000, 5'd5, 5'd4, 5'd2));
        store_and_expect(5'd5, 12'h140, x4 - x2);
        store_and_expect(5'd3, 12'h144, x3);
        store_and_expect(5'd2, 12'h148, x2);
        run_program(1'b0);
    endtask

    task automatic test_load_use();
        riscv_isa_pkg::word_t r;
        logic [11:0]          c_imm;
        r     = $random(seed);
        c_imm = r[11:0];
        start_program();
        set_reg(5'd7, c_imm);
        emit(i_type(riscv_isa_pkg::LOAD, 3'b010, 5'd5, 5'd0, 12'h040));
        emit(r_type(7'h00, 3'b000, 5'd6, 5'd5, 5'd7));
        store_and_expect(5'd6, 12'h180, fill_word(16) + sign_extend(c_imm));
        emit(i_type(riscv_isa_pkg::LOAD, 3'b010, 5'd8, 5'd0, 12'h044));
        emit(r_type(7'h00, 3'b000, 5'd9, 5'd8, 5'd8));
        store_and_expect(5'd9, 12'h184, fill_word(17) + fill_word(17));
        run_program(1'b1);
    endtask

    // stores behind a taken branch or jal must never reach memory
    task automatic test_branches();
        riscv_isa_pkg::word_t link;
        start_program();
        set_reg(5'd1, 12'd5);
        set_reg(5'd2, 12'd5);
        set_reg(5'd3, 12'd7);
        emit(b_type(3'b000, 5'd1, 5'd2, 13'd12));
        emit(s_type(5'd3, 12'h1c0));
        emit(s_type(5'd3, 12'h1c4));
        emit(b_type(3'b001, 5'd1, 5'd2, 13'd8));
        store_and_expect(5'd3, 12'h1c8, 32'd7);
        emit(b_type(3'b001, 5'd1, 5'd3, 13'd8));
        emit(s_type(5'd3, 12'h1cc));
        link = RESET_PC + riscv_isa_pkg::word_t'(prog_len * 4 + 4);
        emit(j_type(5'd4, 21'd8));
        emit(s_type(5'd3, 12'h1d0));
        store_and_expect(5'd4, 12'h1d4, link);
        emit(b_type(3'b000, 5'd0, 5'd0, 13'd8));
        emit(s_type(5'd3, 12'h1d8));
        store_and_expect(5'd1, 12'h1dc, 32'd5);
        run_program(1'b0);
    endtask

    initial begin
        seed = 32'hb6959b8f;
        for (int i = 0; i < 64; i++) begin
            imem[i] = riscv_isa_pkg::NOP_INSTR;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
        end
        test_reset_state();
        test_alu_ops();
        test_forwarding();
        test_load_use();
        test_branches();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: tb.f
rtl/riscv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/riscv_core.sv
dv/riscv_core_assert.sv
dv/riscv_core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module riscv_core_tb -f tb.f -Mdir obj_dir -o riscv_core_sim
./obj_dir/riscv_core_sim
